/* Bender.yml */
package:
  name: vtl_video_chip

sources:
  - src/vtl_pkg.sv
  - src/raster_timing.sv
  - src/io_registers.sv
  - src/memory_slots.sv
  - src/pixel_generator.sv
  - src/vtl_video_chip.sv
  - target: test
    files:
      - testbench/sdram_model.sv
      - testbench/tb_vtl_video_chip.sv

/* src/io_registers.sv */
// ======================================
// z80 i/o ports, banks and mapped i/o
// ======================================
`timescale 1ns/1ns

module io_registers import vtl_pkg::*; #(
	parameter logic [13:0] MAPPED_LO = 14'h2800,
	parameter logic [13:0] MAPPED_HI = 14'h2fff
) (
	input  logic              F14M,
	input  logic              RESET,
	input  logic              cpu_cycle,
	input  logic              IORQ_n,
	input  logic              MREQ_n,
	input  logic              WR_n,
	input  logic [15:0]       A,
	input  logic [7:0]        DO,
	output logic [BANK_W-1:0] bank,
	output logic              bank_is_ram,
	output logic              mapped_io,
	output color_t            border_color,
	output color_t            fg_color,
	output color_t            bg_color,
	output logic              gfx_enabled,
	output vdc_mode_e         mode,
	output logic              page_7,
	output logic              BUZZER,
	output logic              CASOUT
);

	logic [BANK_W-1:0] banks [4];  // one per 16K of cpu space
	logic              io_wr;
	logic              mio_wr;

	function automatic vdc_mode_e decode_mode(input logic [2:0] code);
		if (code[2:1] == 2'b00)
			return GR5;
		else if (code == 3'b011)
			return GR3;
		else
			return UNSUPPORTED;
	endfunction

	assign bank        = banks[A[15:14]];
	assign bank_is_ram = (bank >= 4'd4) && (bank <= 4'd7);
	assign mapped_io   = (bank == 4'd2) && (A[13:0] >= MAPPED_LO) && (A[13:0] <= MAPPED_HI);

	assign io_wr  = cpu_cycle && !IORQ_n && !WR_n;
	assign mio_wr = cpu_cycle && !MREQ_n && !WR_n && mapped_io;

	always_ff @(posedge F14M) begin
		if (RESET) begin
			for (int i = 0; i < 4; i++)
				banks[i] <= '0;
			border_color <= '0;
			fg_color     <= '0;
			bg_color     <= '0;
			mode         <= GR5;
			page_7       <= 1'b1;
			gfx_enabled  <= 1'b0;
			BUZZER       <= 1'b0;
			CASOUT       <= 1'b0;
		end else begin
			if (io_wr) begin
				case (A[7:0])
					8'h40, 8'h41, 8'h42, 8'h43: banks[A[1:0]] <= DO[3:0];
					8'h44: begin
						border_color <= DO[7:4];
						page_7       <= ~DO[3];   // 0 selects page 7
						mode         <= decode_mode(DO[2:0]);
					end
					8'h45: begin
						fg_color <= DO[7:4];
						bg_color <= DO[3:0];
					end
					default: ;  // other ports ignored
				endcase
			end
			if (mio_wr) begin
				gfx_enabled <= DO[3];
				CASOUT      <= DO[2];
				BUZZER      <= DO[0];
			end
		end
	end

endmodule

/* src/memory_slots.sv */
// ======================================
// memory slot scheduler, video and cpu
// ======================================
`timescale 1ns/1ns

module memory_slots import vtl_pkg::*; (
	input  logic                F14M,
	input  logic                RESET,
	input  logic [CNT_W-1:0]    hcnt,
	input  logic                MREQ_n,
	input  logic                RD_n,
	input  logic                WR_n,
	input  logic                IORQ_n,
	input  logic [15:0]         A,
	input  logic [7:0]          DO,
	input  logic [6:0]          KD,
	input  logic                CASIN,
	output logic                CPUENA,
	output logic                WAIT_n,
	output logic [7:0]          DI,
	output logic                cpu_cycle,     // sampling phase, beat not skipped
	input  logic [BANK_W-1:0]   bank,
	input  logic                bank_is_ram,
	input  logic                mapped_io,
	input  logic [SDRAM_AW-1:0] video_addr,
	output logic [SDRAM_AW-1:0] sdram_addr,
	output logic [7:0]          sdram_din,
	output logic                sdram_wr,
	output logic                sdram_rd,
	input  logic [7:0]          sdram_dout
);

	slot_e               slot;
	slot_e               next_slot;
	logic                mreq;
	logic                mreq_old;
	logic                mreq_rise;
	logic                skip_beat;     // whole cpu beat suppressed
	logic                cpu_beat_next; // next clock is cpu phase 0
	logic                cpu_addr_next;
	logic                cpu_sample;
	logic [SDRAM_AW-1:0] cpu_addr;

	assign slot      = slot_e'(hcnt[2:0]);
	assign next_slot = slot_e'(hcnt[2:0] + 3'd1);  // 952 is a multiple of 8

	assign cpu_beat_next = (next_slot == VIDEO_DATA) || (next_slot == CPU_BEAT_B);
	assign cpu_addr_next = (next_slot == CPU_ADDR_A) || (next_slot == CPU_ADDR_B);
	assign cpu_sample    = (slot == CPU_SAMPLE_A) || (slot == CPU_SAMPLE_B);

	assign mreq      = ~MREQ_n;
	assign mreq_rise = mreq & ~mreq_old;
	assign cpu_cycle = cpu_sample & ~skip_beat;
	assign WAIT_n    = 1'b1;  // no wait states

	// bank selects a 16K block
	assign cpu_addr = {{(SDRAM_AW - BANK_W - 14){1'b0}}, bank, A[13:0]};

	always_ff @(posedge F14M) begin
		if (RESET) begin
			mreq_old  <= 1'b0;
			skip_beat <= 1'b0;
			CPUENA    <= 1'b0;
			sdram_rd  <= 1'b0;
			sdram_wr  <= 1'b0;
		end else begin
			// mreq edge checked once per beat, at cpu phase 3
			if (cpu_beat_next) begin
				mreq_old  <= mreq;
				skip_beat <= mreq_rise;
			end
			CPUENA   <= cpu_beat_next & ~mreq_rise;
			sdram_rd <= (next_slot != REFRESH);  // low for the refresh gap
			if (cpu_addr_next)
				sdram_wr <= mreq && !WR_n && !skip_beat && !mapped_io && bank_is_ram;
			else if (cpu_sample)
				sdram_wr <= 1'b0;  // write spans phases 1 and 2
		end
	end

	always_ff @(posedge F14M) begin
		if (next_slot == VIDEO_ADDR) begin
			sdram_addr <= video_addr;
		end else if (cpu_addr_next) begin
			sdram_addr <= cpu_addr;
			sdram_din  <= DO;
		end
		if (cpu_cycle && !RD_n) begin
			if (!IORQ_n)
				DI <= 8'hff;  // no readable i/o ports
			else if (mreq)
				DI <= mapped_io ? {CASIN, KD} : sdram_dout;
		end
	end

endmodule

/* src/pixel_generator.sv */
// ======================================
// video fetch, pixel shifter and palette
// ======================================
`timescale 1ns/1ns

module pixel_generator import vtl_pkg::*; (
	input  logic                F14M,
	input  logic                RESET,
	input  logic [CNT_W-1:0]    hcnt,
	input  logic [7:0]          ycnt,
	input  logic                blank_area,
	input  logic                border_area,
	input  color_t              border_color,
	input  color_t              fg_color,
	input  color_t              bg_color,
	input  logic                gfx_enabled,
	input  vdc_mode_e           mode,
	input  logic                page_7,
	input  logic [7:0]          sdram_dout,
	output logic [SDRAM_AW-1:0] video_addr,
	output logic [5:0]          r,
	output logic [5:0]          g,
	output logic [5:0]          b
);

	slot_e              slot;
	logic [CNT_W-1:0]   xcnt;         // x inside the active window
	logic [CNT_W-1:0]   fetch_x;      // x of the byte being fetched
	logic [VRAM_AW-1:0] row_base;
	logic [VRAM_AW-1:0] vram_offset;
	logic [BANK_W-1:0]  video_page;
	logic [7:0]         fetched;      // byte from the video slot
	logic [7:0]         shifter;
	logic               show_gfx;
	logic               nibble_step;
	color_t             pixel;
	logic [11:0]        rgb;

	assign slot = slot_e'(hcnt[2:0]);
	assign xcnt = hcnt - CNT_W'(H_ACT_START);

	// address sampled at phase 6, byte shown two groups later
	assign fetch_x = xcnt + CNT_W'(16);

	// interleaved rows, y[7:6] * 80 folded into bits 7..4
	assign row_base    = {ycnt[2:0], ycnt[5:3], ycnt[7:6], ycnt[7:6], 4'b0000};
	assign vram_offset = row_base + VRAM_AW'(fetch_x[CNT_W-1:3]);
	assign video_page  = page_7 ? BANK_W'(7) : BANK_W'(3);
	assign video_addr  = {{(SDRAM_AW - BANK_W - VRAM_AW){1'b0}}, video_page, vram_offset};

	assign show_gfx    = !blank_area && !border_area && gfx_enabled && (mode != UNSUPPORTED);
	assign nibble_step = (xcnt[1:0] == 2'd0);  // gr3 pixel is 4 clocks wide

	always_ff @(posedge F14M) begin
		if (slot == VIDEO_DATA)
			fetched <= sdram_dout;
		// load at the byte boundary wins over the shift
		if (slot == VIDEO_ADDR)
			shifter <= fetched;
		else if (show_gfx && mode == GR5)
			shifter <= shifter >> 1;      // lsb first
		else if (show_gfx && mode == GR3 && nibble_step)
			shifter <= shifter >> 4;      // low nibble first
	end

	always_ff @(posedge F14M) begin
		if (RESET)
			pixel <= '0;
		else if (blank_area)
			pixel <= '0;
		else if (!show_gfx)
			pixel <= border_color;   // border, gfx off or unsupported mode
		else if (mode == GR5)
			pixel <= shifter[0] ? fg_color : bg_color;
		else if (nibble_step)
			pixel <= shifter[3:0];   // gr3 holds between steps
	end

	// 4 bit channels padded to 6
	assign rgb = PALETTE[pixel];
	assign r   = {rgb[11:8], 2'b00};
	assign g   = {rgb[7:4], 2'b00};
	assign b   = {rgb[3:0], 2'b00};

endmodule

/* src/raster_timing.sv */
// ======================================
// crt raster counters, syncs and areas
// ======================================
`timescale 1ns/1ns

module raster_timing import vtl_pkg::*; (
	input  logic             F14M,
	input  logic             RESET,
	output logic [CNT_W-1:0] hcnt,         // pixel within line
	output logic [CNT_W-1:0] vcnt,         // line within frame
	output logic [7:0]       ycnt,         // line within active area
	output logic             hsync,
	output logic             vsync,
	output logic             blank_area,
	output logic             border_area
);

	logic line_end;
	logic frame_end;

	assign line_end  = (hcnt == CNT_W'(H_TOTAL - 1));
	assign frame_end = (vcnt == CNT_W'(V_TOTAL - 1));

	always_ff @(posedge F14M) begin
		if (RESET) begin
			hcnt <= '0;
			vcnt <= '0;
			ycnt <= '0;
		end else if (line_end) begin
			hcnt <= '0;
			vcnt <= frame_end ? '0 : vcnt + 1'b1;
			// restart so the first active line is 0
			if (vcnt == CNT_W'(TOP_BORDER - 1))
				ycnt <= '0;
			else
				ycnt <= ycnt + 1'b1;
		end else begin
			hcnt <= hcnt + 1'b1;
		end
	end

	// negative syncs
	assign hsync = !(hcnt < CNT_W'(H_SYNC_W));
	assign vsync = !(vcnt < CNT_W'(V_SYNC_LINES));

	assign blank_area = (hcnt < CNT_W'(H_VIS_START))
		|| (hcnt >= CNT_W'(H_VIS_START + H_VISIBLE))
		|| (vcnt < CNT_W'(V_BLANK_LINES));

	// everything outside the 640x192 window
	assign border_area = (vcnt < CNT_W'(TOP_BORDER))
		|| (vcnt >= CNT_W'(TOP_BORDER + ACTIVE_LINES))
		|| (hcnt < CNT_W'(H_ACT_START))
		|| (hcnt >= CNT_W'(H_ACT_START + ACTIVE_W));

endmodule

/* src/vtl_pkg.sv */
// ======================================
// laser 500 video chip shared definitions
// ======================================
package vtl_pkg;

	// horizontal raster, in pixel clocks
	localparam int H_SYNC_W  = 66;
	localparam int H_BACK    = 78;
	localparam int H_VISIBLE = 798;
	localparam int H_FRONT   = 10;   // unused time before hsync
	localparam int H_TOTAL   = H_SYNC_W + H_BACK + H_VISIBLE + H_FRONT;  // 952

	// vertical raster, in lines
	localparam int V_TOTAL       = 312;
	localparam int V_SYNC_LINES  = 4;
	localparam int V_BLANK_LINES = 2;
	localparam int TOP_BORDER    = 64;
	localparam int ACTIVE_LINES  = 192;

	// horizontal active window
	localparam int LEFT_BORDER  = 72;
	localparam int ACTIVE_W     = 640;
	localparam int H_VIS_START  = H_SYNC_W + H_BACK;          // first visible clock
	localparam int H_ACT_START  = H_VIS_START + LEFT_BORDER;  // 216, multiple of 8

	localparam int CNT_W    = 10;
	localparam int SDRAM_AW = 25;
	localparam int VRAM_AW  = 14;  // 16K video page
	localparam int BANK_W   = 4;

	typedef logic [3:0] color_t;

	typedef enum logic [1:0] {
		GR5,         // 640x192, 1 bpp
		GR3,         // 160x192, 4 bpp
		UNSUPPORTED  // text and other gr modes, shown as border
	} vdc_mode_e;

	// phase within an 8 clock group, value is hcnt[2:0]
	typedef enum logic [2:0] {
		VIDEO_ADDR   = 3'd7,  // video address on the bus
		VIDEO_DATA   = 3'd0,  // video byte returned, cpu beat A
		CPU_ADDR_A   = 3'd1,
		CPU_SAMPLE_A = 3'd2,
		CPU_BEAT_B   = 3'd4,
		CPU_ADDR_B   = 3'd5,
		CPU_SAMPLE_B = 3'd6,
		REFRESH      = 3'd3   // read strobe off
	} slot_e;

	// 4 bits each of red, green, blue
	localparam logic [11:0] PALETTE [16] = '{
		12'h000, 12'h00f, 12'h0a0, 12'h08a,  // black blue green cyan
		12'hf00, 12'h808, 12'h790, 12'h888,  // red magenta yellow grey
		12'h666, 12'h66f, 12'h6f6, 12'h6ff,  // dark grey, bright blue/green/cyan
		12'hf66, 12'hf6f, 12'hff6, 12'hfff   // bright red/magenta/yellow, white
	};

endpackage

/* src/vtl_video_chip.sv */
// ======================================
// laser 500 video and bus chip
// ======================================
`timescale 1ns/1ns

module vtl_video_chip import vtl_pkg::*; #(
	parameter logic [13:0] MAPPED_LO = 14'h2800,  // mapped i/o window in bank 2
	parameter logic [13:0] MAPPED_HI = 14'h2fff
) (
	input  logic                F14M,
	input  logic                RESET,
	input  logic                MREQ_n,
	input  logic                IORQ_n,
	input  logic                RD_n,
	input  logic                WR_n,
	input  logic [15:0]         A,
	input  logic [7:0]          DO,
	input  logic [6:0]          KD,       // keyboard rows
	input  logic                CASIN,
	output logic                CPUENA,
	output logic                WAIT_n,
	output logic [7:0]          DI,
	output logic [SDRAM_AW-1:0] sdram_addr,
	input  logic [7:0]          sdram_dout,
	output logic [7:0]          sdram_din,
	output logic                sdram_wr,
	output logic                sdram_rd,
	output logic                hsync,
	output logic                vsync,
	output logic [5:0]          r,
	output logic [5:0]          g,
	output logic [5:0]          b,
	output logic                BUZZER,
	output logic                CASOUT
);

	logic [CNT_W-1:0]    hcnt;
	logic [7:0]          ycnt;
	logic                blank_area;
	logic                border_area;
	logic [BANK_W-1:0]   bank;
	logic                bank_is_ram;
	logic                mapped_io;
	logic                cpu_cycle;
	color_t              border_color;
	color_t              fg_color;
	color_t              bg_color;
	logic                gfx_enabled;
	vdc_mode_e           mode;
	logic                page_7;
	logic [SDRAM_AW-1:0] video_addr;

	// connections are by matching names
	raster_timing i_raster (.vcnt(), .*);

	io_registers #(
		.MAPPED_LO(MAPPED_LO),
		.MAPPED_HI(MAPPED_HI)
	) i_io (.*);

	memory_slots i_slots (.*);

	pixel_generator i_pixels (.*);

endmodule

/* testbench/sdram_model.sv */
// ======================================
// byte wide memory model, one cycle read
// ======================================
`timescale 1ns/1ns

module sdram_model (
	input  logic        clk,
	input  logic [24:0] addr,
	input  logic [7:0]  din,
	input  logic        rd,
	input  logic        wr,
	output logic [7:0]  dout
);

	logic [7:0] mem [65536];  // upper address bits fold onto 64K

	initial dout = 8'h00;

	// same byte everywhere
	task automatic fill(input logic [7:0] value);
		for (int i = 0; i < 65536; i++)
			mem[i] = value;
	endtask

	always @(posedge clk) begin
		if (wr)
			mem[addr[15:0]] <= din;
		if (rd)
			dout <= mem[addr[15:0]];  // data one clock after the address
	end

endmodule

/* testbench/tb_vtl_video_chip.sv */
// ======================================
// testbench for the laser 500 video chip
// ======================================
`timescale 1ns/1ns

module tb_vtl_video_chip import vtl_pkg::*; ();

	localparam int FRAME     = H_TOTAL * V_TOTAL;
	localparam int MAX_TICKS = FRAME * 4 + FRAME * 4 / 10;  // 4 frames plus 10%

	logic F14M, RESET, MREQ_n, IORQ_n, RD_n, WR_n, CASIN;
	logic [15:0] A;
	logic [7:0] DO, DI, sdram_din, sdram_dout;
	logic [6:0] KD;
	logic CPUENA, WAIT_n, sdram_wr, sdram_rd, hsync, vsync, BUZZER, CASOUT;
	logic [SDRAM_AW-1:0] sdram_addr;
	logic [5:0] r, g, b;

	int     tick;           // clocks since reset which mirror the raster
	int     cycles;
	logic   last_p3;        // mreq seen at previous phase 3
	logic   skip_next;      // beat expected to be skipped
	logic   exp_blank_d;    // area of the pixel now on r/g/b
	logic   exp_border_d;
	logic   window_on;      // pixel colours checked
	logic   no_ram_write;
	color_t exp_border;
	color_t exp_active;
	logic [7:0]  data;
	logic [13:0] off;
	logic [17:0] phys;
	logic [7:0]  kd_val;

	vtl_video_chip i_dut (.*);

	sdram_model i_mem (
		.clk(F14M), .addr(sdram_addr), .din(sdram_din),
		.rd(sdram_rd), .wr(sdram_wr), .dout(sdram_dout)
	);

	task automatic report_failure(input string msg);
		$display("FAILED at %0t: %s", $time, msg);
		$display("Test failed");
		$fatal(1);
	endtask

	function automatic logic [17:0] palette_rgb(input color_t c);
		logic [11:0] e;
		e = PALETTE[c];
		return {e[11:8], 2'b00, e[7:4], 2'b00, e[3:0], 2'b00};
	endfunction

	function automatic logic in_blank(input int t);
		int h;
		int v;
		h = t % H_TOTAL;
		v = (t / H_TOTAL) % V_TOTAL;
		return (h < H_SYNC_W + H_BACK) || (h >= H_SYNC_W + H_BACK + H_VISIBLE)
			|| (v < V_BLANK_LINES);
	endfunction

	function automatic logic in_border(input int t);
		int h;
		int v;
		h = t % H_TOTAL;
		v = (t / H_TOTAL) % V_TOTAL;
		return (v < TOP_BORDER) || (v >= TOP_BORDER + ACTIVE_LINES)
			|| (h < H_SYNC_W + H_BACK + LEFT_BORDER)
			|| (h >= H_SYNC_W + H_BACK + LEFT_BORDER + ACTIVE_W);
	endfunction

	initial begin
		F14M = 1'b0;
		forever #20 F14M = ~F14M;
	end

	// reference raster and beat tracking
	always_ff @(posedge F14M) begin
		if (RESET) begin
			tick         <= 0;
			last_p3      <= 1'b0;
			skip_next    <= 1'b0;
			exp_blank_d  <= 1'b1;
			exp_border_d <= 1'b1;
		end else begin
			tick         <= tick + 1;
			exp_blank_d  <= in_blank(tick);   // pixel is one clock late
			exp_border_d <= in_border(tick);
			if (tick % 4 == 3) begin
				last_p3   <= !MREQ_n;
				skip_next <= !MREQ_n && !last_p3;  // rising mreq
			end
		end
	end

	always_ff @(posedge F14M) begin
		cycles <= cycles + 1;
		if (cycles > MAX_TICKS) begin
			$display("Timeout: the test did not finish in time");
			$display("Test failed");
			$fatal(1);
		end
	end

	assert property (@(posedge F14M) disable iff (RESET)
		hsync == ((tick % H_TOTAL) >= H_SYNC_W))
		else report_failure("hsync timing wrong");
	assert property (@(posedge F14M) disable iff (RESET)
		vsync == (((tick / H_TOTAL) % V_TOTAL) >= V_SYNC_LINES))
		else report_failure("vsync timing wrong");
	assert property (@(posedge F14M) disable iff (RESET)
		CPUENA == ((tick % 4 == 0) && (tick != 0) && !skip_next))
		else report_failure("CPUENA pulse wrong");
	assert property (@(posedge F14M) disable iff (RESET)
		WAIT_n)
		else report_failure("WAIT_n driven low");
	assert property (@(posedge F14M) disable iff (RESET)
		sdram_rd == ((tick != 0) && (tick % 8 != 3)))
		else report_failure("sdram_rd not low exactly in the refresh gap");
	assert property (@(posedge F14M) disable iff (RESET)
		sdram_wr |-> (sdram_addr == SDRAM_AW'(phys)))
		else report_failure("CPU write address wrong");
	assert property (@(posedge F14M) disable iff (RESET)
		no_ram_write |-> !sdram_wr)
		else report_failure("sdram_wr raised for a non-RAM bank");
	assert property (@(posedge F14M) disable iff (RESET)
		exp_blank_d |-> ({r, g, b} == 18'd0))
		else report_failure("colour not zero in blanking");
	assert property (@(posedge F14M) disable iff (RESET)
		(window_on && !exp_blank_d && exp_border_d) |-> ({r, g, b} == palette_rgb(exp_border)))
		else report_failure("border colour wrong");
	assert property (@(posedge F14M) disable iff (RESET)
		(window_on && !exp_blank_d && !exp_border_d) |-> ({r, g, b} == palette_rgb(exp_active)))
		else report_failure("active area colour wrong");

	// one bus cycle held over three cpu beats
	task automatic cpu_access(input logic [15:0] addr, input logic [7:0] wdata,
		input logic is_io, input logic is_write);
		@(posedge F14M);
		A      <= addr;
		DO     <= wdata;
		MREQ_n <= is_io;
		IORQ_n <= !is_io;
		WR_n   <= !is_write;
		RD_n   <= is_write;
		repeat (3) begin
			@(posedge F14M);
			while (!CPUENA)
				@(posedge F14M);
		end
		repeat (3) @(posedge F14M);
		MREQ_n <= 1'b1;
		IORQ_n <= 1'b1;
		WR_n   <= 1'b1;
		RD_n   <= 1'b1;
		@(posedge F14M);
	endtask

	// check from one vsync to line 300 of the same frame
	task automatic check_frame();
		@(negedge vsync);
		@(posedge F14M);
		window_on <= 1'b1;
		do @(posedge F14M); while (((tick / H_TOTAL) % V_TOTAL) != 300);
		window_on <= 1'b0;
		@(posedge F14M);
	endtask

	initial begin
		void'($urandom(51020));
		RESET = 1'b1;
		MREQ_n = 1'b1;
		IORQ_n = 1'b1;
		RD_n = 1'b1;
		WR_n = 1'b1;
		A = 16'h0000;
		DO = 8'h00;
		KD = 7'h7f;
		CASIN = 1'b0;
		window_on = 1'b0;
		no_ram_write = 1'b0;
		exp_border = '0;
		exp_active = '0;
		repeat (10) @(posedge F14M);
		RESET <= 1'b0;

		// bank 1 to RAM page 5 then write and read back
		cpu_access(16'h0041, 8'h05, 1'b1, 1'b1);
		data = 8'($urandom);
		off  = 14'($urandom);
		phys = {4'd5, off};
		cpu_access({2'b01, off}, data, 1'b0, 1'b1);
		assert (i_mem.mem[phys[15:0]] == data)
			else report_failure("memory does not hold the written byte");
		cpu_access({2'b01, off}, 8'h00, 1'b0, 1'b0);
		assert (DI == data) else report_failure("CPU read data wrong");

		// bank 1 to ROM page 0 so no write reaches memory
		cpu_access(16'h0041, 8'h00, 1'b1, 1'b1);
		no_ram_write <= 1'b1;
		cpu_access({2'b01, off}, ~data, 1'b0, 1'b1);
		no_ram_write <= 1'b0;

		// mapped i/o through bank 2
		cpu_access(16'h0042, 8'h02, 1'b1, 1'b1);
		data = (8'($urandom) & 8'hf0) | 8'h05;
		cpu_access(16'ha800, data, 1'b0, 1'b1);
		assert (BUZZER == data[0] && CASOUT == data[2])
			else report_failure("BUZZER or CASOUT wrong");
		kd_val = 8'($urandom);
		KD    <= kd_val[6:0];
		CASIN <= kd_val[7];
		cpu_access(16'ha900, 8'h00, 1'b0, 1'b0);
		assert (DI == kd_val) else report_failure("mapped i/o read wrong");

		// gr5 foreground on a random border
		exp_border = color_t'($urandom);
		exp_active = color_t'($urandom);
		cpu_access(16'h0044, {exp_border, 4'b0000}, 1'b1, 1'b1);
		cpu_access(16'h0045, {exp_active, ~exp_active}, 1'b1, 1'b1);
		cpu_access(16'ha800, 8'h08, 1'b0, 1'b1);  // graphics on
		i_mem.fill(8'hff);
		check_frame();

		// gr5 background
		exp_active = ~exp_active;
		i_mem.fill(8'h00);
		check_frame();

		// gr3 with colour 5 in both nibbles
		cpu_access(16'h0044, {exp_border, 4'b1011}, 1'b1, 1'b1);
		exp_active = 4'd5;
		i_mem.fill(8'h55);
		check_frame();

		$display("Test completed successfully");
		$finish;
	end

endmodule

/* vtl_video_chip.f */
src/vtl_pkg.sv
src/raster_timing.sv
src/io_registers.sv
src/memory_slots.sv
src/pixel_generator.sv
src/vtl_video_chip.sv
testbench/sdram_model.sv
testbench/tb_vtl_video_chip.sv
